/* src.f */
src/fsmc_pkg.sv
src/fsmc_sync.sv
src/fsmc_slave.sv
src/fsmc_wb_master.sv
src/wb_reg_bank.sv
src/fsmc_bridge_top.sv
dv/fsmc_bridge_checker.sv
dv/tb_fsmc_bridge.sv

/* Bender.yml */
package:
  name: fsmc_bridge

sources:
  # synthesizable bridge, package first
  - files:
      - src/fsmc_pkg.sv
      - src/fsmc_sync.sv
      - src/fsmc_slave.sv
      - src/fsmc_wb_master.sv
      - src/wb_reg_bank.sv
      - src/fsmc_bridge_top.sv

  # checker and testbench, top module tb_fsmc_bridge
  - target: test
    files:
      - dv/fsmc_bridge_checker.sv
      - dv/tb_fsmc_bridge.sv

/* dv/tb_fsmc_bridge.sv */
/*
 * testbench for the host bus to wishbone bridge
 * muxed-bus host model, reference register model, directed and random runs
 */
`timescale 1ns/100ps
`default_nettype none

module tb_fsmc_bridge;

    import fsmc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY    = 10;    // drive and sample point after posedge
    localparam int NREGION    = 2**CS_WIDTH_DEF;
    localparam int NREG       = 2**REG_ADDR_WIDTH_DEF;
    localparam int N_RANDOM   = 200;
    localparam int HOLD_WAIT  = DATA_HOLD_CYCLES_DEF + 3;
    // reset scan, region rw, no-select, random, release
    localparam int N_ACCESS   = NREGION * NREG + 3 * NREGION + 9 + N_RANDOM + 8;
    localparam logic [OFFSET_WIDTH-1:0] FIX_OFS = OFFSET_WIDTH'(5);

    logic                      clk;
    logic                      reset_n;
    logic                      nadv;
    logic                      nwe;
    logic                      noe;
    logic [ADDR_WIDTH_DEF-1:0] host_ad;
    logic                      host_drive;  // host owns AD
    wire  [ADDR_WIDTH_DEF-1:0] ad;

    logic [DATA_WIDTH_DEF-1:0] ref_mem [NREGION][NREG];  // predicted bank contents
    string                     test_name;
    int                        test_checks;
    int                        test_errs;
    int                        total_checks;
    int                        total_errs;
    int                        n_tests;

    assign ad = host_drive ? host_ad : {ADDR_WIDTH_DEF{1'bz}};

    fsmc_bridge_top i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .ad      (ad),
        .nadv    (nadv),
        .nwe     (nwe),
        .noe     (noe)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================================
    // host bus model
    // ==================================================================
    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic check_value(input string what, input logic [ADDR_WIDTH_DEF-1:0] exp,
                               input logic [ADDR_WIDTH_DEF-1:0] act);
        test_checks++;
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", what, exp, act);
            test_errs++;
        end
    endtask

    task automatic write_access(input logic [HIGH_ADDR_WIDTH_DEF-1:0] high,
                                input logic [CS_WIDTH_DEF-1:0] region,
                                input logic [OFFSET_WIDTH-1:0] offset,
                                input logic [DATA_WIDTH_DEF-1:0] data);
        next_cycle();
        host_ad    = {high, region, offset};  // address phase
        host_drive = 1'b1;
        nadv       = 1'b0;
        next_cycle();
        nadv = 1'b1;
        repeat (6) next_cycle();
        host_ad = ADDR_WIDTH_DEF'(data);      // data phase
        nwe     = 1'b0;
        repeat (2) next_cycle();
        nwe = 1'b1;
        repeat (5) next_cycle();              // data held past the capture
        host_drive = 1'b0;
        // only a selected write reaches a bank
        if (high == HIGH_ADDR_CS_DEF) begin
            ref_mem[region][offset[REG_ADDR_WIDTH_DEF-1:0]] = data;
        end
    endtask

    task automatic read_access(input logic [HIGH_ADDR_WIDTH_DEF-1:0] high,
                               input logic [CS_WIDTH_DEF-1:0] region,
                               input logic [OFFSET_WIDTH-1:0] offset);
        logic [ADDR_WIDTH_DEF-1:0] exp;
        logic [ADDR_WIDTH_DEF-1:0] got;
        if (high == HIGH_ADDR_CS_DEF) begin
            exp = ADDR_WIDTH_DEF'(ref_mem[region][offset[REG_ADDR_WIDTH_DEF-1:0]]);
        end else begin
            exp = {ADDR_WIDTH_DEF{1'bz}};     // nobody answers
        end
        next_cycle();
        host_ad    = {high, region, offset};
        host_drive = 1'b1;
        nadv       = 1'b0;
        next_cycle();
        nadv = 1'b1;
        repeat (6) next_cycle();              // bus margin before NOE
        host_drive = 1'b0;
        noe        = 1'b0;
        repeat (4) next_cycle();
        got = ad;                             // just before NOE rises
        noe = 1'b1;
        check_value(test_name, exp, got);
        repeat (HOLD_WAIT) next_cycle();
        check_value({test_name, "/release"}, {ADDR_WIDTH_DEF{1'bz}}, ad);
    endtask

    // any high field except the selected one
    function automatic logic [HIGH_ADDR_WIDTH_DEF-1:0] other_high(input int unsigned pick);
        logic [HIGH_ADDR_WIDTH_DEF-1:0] h;
        h = HIGH_ADDR_WIDTH_DEF'(pick % (2**HIGH_ADDR_WIDTH_DEF - 1));
        if (h >= HIGH_ADDR_CS_DEF) begin
            h = h + 1'b1;                     // skip over the match
        end
        return h;
    endfunction

    task automatic finish_test();
        $display("%-12s %0d checks, %0d errors", test_name, test_checks, test_errs);
        total_checks += test_checks;
        total_errs   += test_errs;
        n_tests++;
        test_checks = 0;
        test_errs   = 0;
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        int                              r;
        int                              i;
        logic [31:0]                     sel;
        logic [HIGH_ADDR_WIDTH_DEF-1:0]  high;
        void'($urandom(32'hcf1e));
        clk          = 1'b0;
        reset_n      = 1'b0;
        nadv         = 1'b1;  // strobes idle high
        nwe          = 1'b1;
        noe          = 1'b1;
        host_ad      = '0;
        host_drive   = 1'b0;
        test_checks  = 0;
        test_errs    = 0;
        total_checks = 0;
        total_errs   = 0;
        n_tests      = 0;
        for (r = 0; r < NREGION; r++) begin
            for (i = 0; i < NREG; i++) begin
                ref_mem[r][i] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #DRV_DLY;
        reset_n = 1'b1;

        test_name = "reset_read";
        for (r = 0; r < NREGION; r++) begin
            for (i = 0; i < NREG; i++) begin
                read_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(r), OFFSET_WIDTH'(i));
            end
        end
        finish_test();

        // same register in every region, distinct data per region
        test_name = "region_rw";
        for (r = 0; r < NREGION; r++) begin
            write_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(r), FIX_OFS,
                         16'ha5c0 ^ DATA_WIDTH_DEF'(r * 16'h1111));
            read_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(r), FIX_OFS);
        end
        for (r = 0; r < NREGION; r++) begin
            read_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(r), FIX_OFS);
        end
        finish_test();

        test_name = "no_select";
        for (i = 0; i < 3; i++) begin
            high = other_high(i);
            write_access(high, CS_WIDTH_DEF'(i), FIX_OFS, 16'hdead);
            read_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(i), FIX_OFS);  // unchanged
            read_access(high, CS_WIDTH_DEF'(i), FIX_OFS);              // AD left floating
        end
        finish_test();

        test_name = "random";
        repeat (N_RANDOM) begin
            sel  = $urandom;
            high = (sel[1:0] == 2'b00) ? other_high($urandom) : HIGH_ADDR_CS_DEF;
            if (sel[2]) begin
                write_access(high, CS_WIDTH_DEF'($urandom), OFFSET_WIDTH'($urandom),
                             DATA_WIDTH_DEF'($urandom));
            end else begin
                read_access(high, CS_WIDTH_DEF'($urandom), OFFSET_WIDTH'($urandom));
            end
        end
        finish_test();

        test_name = "ad_release";
        for (i = 0; i < 8; i++) begin
            read_access(HIGH_ADDR_CS_DEF, CS_WIDTH_DEF'(i % NREGION), OFFSET_WIDTH'(i));
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, total_checks, total_errs, i_dut.u_checker.fails);
        if (total_errs == 0 && i_dut.u_checker.fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // upper bound of 40 cycles per host access
    initial begin
        #(N_ACCESS * 40 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, host accesses did not complete",
                 N_ACCESS * 40);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/fsmc_bridge_checker.sv */
/*
 * bus rule checker for the host bridge
 * bound into the top level, watches wishbone, request and AD drive timing
 */
`timescale 1ns/100ps
`default_nettype none

module fsmc_bridge_checker #(
    parameter int CS_WIDTH         = fsmc_pkg::CS_WIDTH_DEF,
    parameter int DATA_HOLD_CYCLES = fsmc_pkg::DATA_HOLD_CYCLES_DEF
) (
    input  wire logic                                clk,
    input  wire logic                                reset_n,
    input  wire logic                                noe,     // host pin
    input  wire logic                                ad_oe,   // slave drives AD
    input  wire logic [2**CS_WIDTH-1:0]              wb_cyc,
    input  wire fsmc_pkg::wb_m2s_t                   wb_m2s,
    input  wire fsmc_pkg::wb_s2m_t [2**CS_WIDTH-1:0] wb_s2m,
    input  wire fsmc_pkg::fsmc_req_t                 req
);

    localparam int NREGION = 2**CS_WIDTH;
    localparam int NOE_QUIET = DATA_HOLD_CYCLES + 4;  // samples of NOE high before AD is free

    int unsigned           fails = 0;  // read by the testbench at the end
    logic [NREGION-1:0]    ack_vec;

    always_comb begin
        for (int i = 0; i < NREGION; i++) begin
            ack_vec[i] = wb_s2m[i].ack;
        end
    end

    // ==================================================================
    // wishbone classic and request rules
    // ==================================================================
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!reset_n)
        wb_m2s.stb |-> (|wb_cyc))
        else begin $error("stb high with no cyc set"); fails++; end

    a_cyc_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(wb_cyc))
        else begin $error("more than one region cyc high"); fails++; end

    a_ack_closes: assert property (@(posedge clk) disable iff (!reset_n)
        (|ack_vec) |=> (wb_cyc == '0))
        else begin $error("cyc still high the cycle after ack"); fails++; end

    a_req_idle: assert property (@(posedge clk) disable iff (!reset_n)
        req.valid |-> (wb_cyc == '0))
        else begin $error("request arrived while a cycle was open"); fails++; end

    // AD released within the hold window once NOE is back up
    a_ad_release: assert property (@(posedge clk) disable iff (!reset_n)
        noe [*NOE_QUIET] |-> !ad_oe)
        else begin $error("AD still driven long after NOE rose"); fails++; end

endmodule

bind fsmc_bridge_top fsmc_bridge_checker #(
    .CS_WIDTH         (CS_WIDTH),
    .DATA_HOLD_CYCLES (DATA_HOLD_CYCLES)
) u_checker (
    .clk     (clk),
    .reset_n (reset_n),
    .noe     (noe),
    .ad_oe   (u_slave.oe_q),
    .wb_cyc  (wb_cyc),
    .wb_m2s  (wb_m2s),
    .wb_s2m  (wb_s2m),
    .req     (req)
);

`default_nettype wire

/* src/fsmc_bridge_top.sv */
/*
 * host bus to wishbone bridge, top level
 * synchronizer, slave, master and one register bank per region
 */
`timescale 1ns/100ps
`default_nettype none

module fsmc_bridge_top #(
    parameter int ADDR_WIDTH       = fsmc_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH       = fsmc_pkg::DATA_WIDTH_DEF,
    parameter int CS_WIDTH         = fsmc_pkg::CS_WIDTH_DEF,
    parameter int HIGH_ADDR_WIDTH  = fsmc_pkg::HIGH_ADDR_WIDTH_DEF,
    parameter int OFFSET_WIDTH     = fsmc_pkg::OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH   = fsmc_pkg::REG_ADDR_WIDTH_DEF,
    parameter logic [HIGH_ADDR_WIDTH-1:0] HIGH_ADDR_CS = fsmc_pkg::HIGH_ADDR_CS_DEF,
    parameter int DATA_HOLD_CYCLES = fsmc_pkg::DATA_HOLD_CYCLES_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    inout  wire       [ADDR_WIDTH-1:0] ad,
    input  wire logic                  nadv,
    input  wire logic                  nwe,
    input  wire logic                  noe
);

    import fsmc_pkg::*;

    fsmc_strobe_t                   strobe;
    fsmc_req_t                      req;
    logic [DATA_WIDTH-1:0]          rdata;
    logic                           done;
    logic [2**CS_WIDTH-1:0]         wb_cyc;   // one per region
    wb_m2s_t                        wb_m2s;   // shared by all banks
    wb_s2m_t [2**CS_WIDTH-1:0]      wb_s2m;

    fsmc_sync u_sync (
        .clk     (clk),
        .reset_n (reset_n),
        .nadv    (nadv),
        .nwe     (nwe),
        .noe     (noe),
        .strobe  (strobe)
    );

    fsmc_slave #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .DATA_WIDTH       (DATA_WIDTH),
        .CS_WIDTH         (CS_WIDTH),
        .HIGH_ADDR_WIDTH  (HIGH_ADDR_WIDTH),
        .HIGH_ADDR_CS     (HIGH_ADDR_CS),
        .DATA_HOLD_CYCLES (DATA_HOLD_CYCLES)
    ) u_slave (
        .clk     (clk),
        .reset_n (reset_n),
        .ad      (ad),
        .strobe  (strobe),
        .req     (req),
        .rdata   (rdata),
        .done    (done)
    );

    fsmc_wb_master #(
        .CS_WIDTH     (CS_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) u_master (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req),
        .rdata   (rdata),
        .done    (done),
        .wb_cyc  (wb_cyc),
        .wb_m2s  (wb_m2s),
        .wb_s2m  (wb_s2m)
    );

    // ==================================================================
    // one bank per chip-select region
    // ==================================================================
    for (genvar r = 0; r < 2**CS_WIDTH; r++) begin : g_bank
        wb_reg_bank #(
            .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
            .DATA_WIDTH     (DATA_WIDTH)
        ) u_bank (
            .clk     (clk),
            .reset_n (reset_n),
            .wb_cyc  (wb_cyc[r]),
            .wb_m2s  (wb_m2s),
            .wb_s2m  (wb_s2m[r])
        );
    end

endmodule

`default_nettype wire

/* src/wb_reg_bank.sv */
/*
 * wishbone classic register bank
 * one chip-select region, single-cycle ack, registered read data
 */
`timescale 1ns/100ps
`default_nettype none

module wb_reg_bank #(
    parameter int REG_ADDR_WIDTH = fsmc_pkg::REG_ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH     = fsmc_pkg::DATA_WIDTH_DEF
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              wb_cyc,
    input  wire fsmc_pkg::wb_m2s_t wb_m2s,
    output fsmc_pkg::wb_s2m_t      wb_s2m
);

    localparam int DEPTH = 2**REG_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0]     regs [DEPTH];
    logic [REG_ADDR_WIDTH-1:0] idx;         // low offset bits only
    logic                      access;      // cyc and stb, not yet acked
    logic                      ack_q;
    logic [DATA_WIDTH-1:0]     dat_q;

    assign idx    = wb_m2s.adr[REG_ADDR_WIDTH-1:0];
    assign access = wb_cyc & wb_m2s.stb & ~ack_q;  // no second ack while stb stays

    // ==================================================================
    // storage
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (access && wb_m2s.we) begin
            regs[idx] <= wb_m2s.dat;
        end
    end

    // ack one cycle after the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= regs[idx];  // old value on a write, unused then
        end
    end

    assign wb_s2m.ack = ack_q;
    assign wb_s2m.dat = dat_q;

endmodule

`default_nettype wire

/* src/fsmc_wb_master.sv */
/*
 * wishbone classic master
 * runs one single-beat cycle per slave request and returns ack data
 */
`timescale 1ns/100ps
`default_nettype none

module fsmc_wb_master #(
    parameter int CS_WIDTH     = fsmc_pkg::CS_WIDTH_DEF,
    parameter int OFFSET_WIDTH = fsmc_pkg::OFFSET_WIDTH,
    parameter int DATA_WIDTH   = fsmc_pkg::DATA_WIDTH_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire fsmc_pkg::fsmc_req_t   req,
    output logic [DATA_WIDTH-1:0]      rdata,
    output logic                       done,
    output logic [2**CS_WIDTH-1:0]     wb_cyc,
    output fsmc_pkg::wb_m2s_t          wb_m2s,
    input  wire fsmc_pkg::wb_s2m_t [2**CS_WIDTH-1:0] wb_s2m
);

    localparam int NREG = 2**CS_WIDTH;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT_ACK
    } state_t;

    state_t                  state_q;
    logic [NREG-1:0]         cyc_q;
    logic                    stb_q;
    logic                    we_q;
    logic [CS_WIDTH-1:0]     region_q;   // steers the response mux
    logic [OFFSET_WIDTH-1:0] offset_q;
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic                    ack_sel;

    // response from the addressed bank only
    assign ack_sel = wb_s2m[region_q].ack;
    assign rdata   = wb_s2m[region_q].dat;
    assign done    = (state_q == ST_WAIT_ACK) && ack_sel;  // pulses with ack

    // ==================================================================
    // cycle control
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= ST_IDLE;
            cyc_q    <= '0;
            stb_q    <= 1'b0;
            region_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req.valid) begin
                        cyc_q    <= {{(NREG-1){1'b0}}, 1'b1} << req.region;  // one-hot
                        stb_q    <= 1'b1;
                        region_q <= req.region;
                        state_q  <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    // requests here are dropped
                    if (ack_sel) begin
                        cyc_q   <= '0;
                        stb_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload, only loaded on accept
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req.valid) begin
            we_q     <= req.we;
            offset_q <= req.offset;
            wdata_q  <= req.wdata;
        end
    end

    assign wb_cyc     = cyc_q;
    assign wb_m2s.stb = stb_q;
    assign wb_m2s.we  = we_q;
    assign wb_m2s.adr = offset_q;
    assign wb_m2s.dat = wdata_q;

endmodule

`default_nettype wire

/* src/fsmc_slave.sv */
/*
 * muxed-bus host slave
 * latches the address on NADV, selects by the high field, issues read and
 * write requests, and drives AD with read data plus a hold after NOE
 */
`timescale 1ns/100ps
`default_nettype none

module fsmc_slave #(
    parameter int ADDR_WIDTH       = fsmc_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH       = fsmc_pkg::DATA_WIDTH_DEF,
    parameter int CS_WIDTH         = fsmc_pkg::CS_WIDTH_DEF,
    parameter int HIGH_ADDR_WIDTH  = fsmc_pkg::HIGH_ADDR_WIDTH_DEF,
    parameter logic [HIGH_ADDR_WIDTH-1:0] HIGH_ADDR_CS = fsmc_pkg::HIGH_ADDR_CS_DEF,
    parameter int DATA_HOLD_CYCLES = fsmc_pkg::DATA_HOLD_CYCLES_DEF
) (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    inout  wire       [ADDR_WIDTH-1:0]  ad,
    input  wire fsmc_pkg::fsmc_strobe_t strobe,
    output fsmc_pkg::fsmc_req_t         req,
    input  wire logic [DATA_WIDTH-1:0]  rdata,
    input  wire logic                   done
);

    import fsmc_pkg::*;

    localparam int HOLD_W = $clog2(DATA_HOLD_CYCLES + 1);

    fsmc_addr_u          ad_in;     // live view of the pins
    fsmc_addr_u          addr_q;    // address phase copy
    logic                hit;       // high field matches
    logic                sel_q;     // access belongs to this slave
    logic                rd_req;
    logic                wr_req;
    logic [CS_WIDTH-1:0] region_sel;
    logic                pend_rd;   // read in flight on wishbone
    logic [DATA_WIDTH-1:0] rd_hold; // data presented on AD
    logic                oe_q;      // AD output enable
    logic                holding;   // NOE gone, counting hold cycles
    logic [HOLD_W-1:0]   hold_cnt;
    logic                hold_done;

    assign ad_in = ad;
    assign hit   = (ad_in.fld.high == HIGH_ADDR_CS);

    // ==================================================================
    // address phase and selection
    // ==================================================================
    always_ff @(posedge clk) begin
        if (strobe.nadv_rise) begin
            addr_q.raw <= ad_in.raw;
        end
    end

    // read fetch starts right at the address phase, write waits for NWE
    assign rd_req = strobe.nadv_rise & hit;
    assign wr_req = strobe.nwe_rise & sel_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sel_q <= 1'b0;
        end else if (strobe.nadv_rise) begin
            sel_q <= hit;      // a new address always re-decides
        end else if (wr_req || hold_done) begin
            sel_q <= 1'b0;     // write issued or read data released
        end
    end

    // region from the pins during the address phase, else from the latch
    assign region_sel = strobe.nadv_rise ? ad_in.fld.region : addr_q.fld.region;

    always_comb begin
        req = '0;
        if (rd_req) begin
            req.valid  = 1'b1;
            req.we     = 1'b0;
            req.region = region_sel;
            req.offset = ad_in.fld.offset;
        end else if (wr_req) begin
            req.valid  = 1'b1;
            req.we     = 1'b1;
            req.region = region_sel;
            req.offset = addr_q.fld.offset;
            req.wdata  = ad[DATA_WIDTH-1:0];  // data phase still held by host
        end
    end

    // ==================================================================
    // read return
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_rd <= 1'b0;
        end else if (rd_req) begin
            pend_rd <= 1'b1;
        end else if (done) begin
            pend_rd <= 1'b0;   // write completions leave rd_hold alone
        end
    end

    always_ff @(posedge clk) begin
        if (done && pend_rd) begin
            rd_hold <= rdata;
        end
    end

    // ==================================================================
    // output enable with hold after NOE
    // ==================================================================
    assign hold_done = holding && (hold_cnt == HOLD_W'(1));  // oe falls here

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            oe_q     <= 1'b0;
            holding  <= 1'b0;
            hold_cnt <= '0;
        end else if (strobe.noe_rise && oe_q) begin
            holding  <= 1'b1;
            hold_cnt <= HOLD_W'(DATA_HOLD_CYCLES);
        end else if (holding) begin
            hold_cnt <= hold_cnt - 1'b1;
            if (hold_done) begin
                oe_q    <= 1'b0;
                holding <= 1'b0;
            end
        end else if (sel_q && strobe.noe_low) begin
            oe_q <= 1'b1;      // host is reading this slave
        end
    end

    // zero-extend into the upper address bits
    assign ad = oe_q ? {{(ADDR_WIDTH-DATA_WIDTH){1'b0}}, rd_hold} : {ADDR_WIDTH{1'bz}};

endmodule

`default_nettype wire

/* src/fsmc_sync.sv */
/*
 * host strobe synchronizer
 * one register stage on NADV/NWE/NOE, then registered rising-edge flags
 */
`timescale 1ns/100ps
`default_nettype none

module fsmc_sync (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            nadv,
    input  wire logic            nwe,
    input  wire logic            noe,
    output fsmc_pkg::fsmc_strobe_t strobe
);

    logic [2:0] sync_q;   // {nadv, nwe, noe}
    logic [2:0] prev_q;   // one cycle older copy
    logic [2:0] rise_q;   // registered edge flags

    // single stage is enough at the host's strobe rates
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= 3'b111;  // strobes idle high
            prev_q <= 3'b111;
            rise_q <= 3'b000;
        end else begin
            sync_q <= {nadv, nwe, noe};
            prev_q <= sync_q;
            rise_q <= ~prev_q & sync_q;  // was low, now high
        end
    end

    // rise flags land 2 cycles after the pin edge
    assign strobe.nadv_rise = rise_q[2];
    assign strobe.nwe_rise  = rise_q[1];
    assign strobe.noe_rise  = rise_q[0];
    assign strobe.noe_low   = ~sync_q[0];  // synchronized level, 1 cycle late

endmodule

`default_nettype wire

/* src/fsmc_pkg.sv */
/*
 * fsmc bridge shared definitions
 * default widths, latched address view, strobe, request and wishbone structs
 */
`default_nettype none

package fsmc_pkg;

    // ==================================================================
    // default geometry
    // ==================================================================
    localparam int ADDR_WIDTH_DEF       = 18;  // muxed AD width
    localparam int DATA_WIDTH_DEF       = 16;
    localparam int CS_WIDTH_DEF         = 2;   // region select bits below the high field
    localparam int HIGH_ADDR_WIDTH_DEF  = 2;   // top address bits compared for select
    localparam logic [HIGH_ADDR_WIDTH_DEF-1:0] HIGH_ADDR_CS_DEF = 2'b01;
    localparam int DATA_HOLD_CYCLES_DEF = 2;   // AD hold after NOE rises

    // word offset inside one region
    localparam int OFFSET_WIDTH = ADDR_WIDTH_DEF - HIGH_ADDR_WIDTH_DEF - CS_WIDTH_DEF;

    localparam int REG_ADDR_WIDTH_DEF = 4;     // 16 words per bank

    // ==================================================================
    // latched address word
    // ==================================================================
    typedef struct packed {
        logic [HIGH_ADDR_WIDTH_DEF-1:0] high;   // must equal HIGH_ADDR_CS
        logic [CS_WIDTH_DEF-1:0]        region; // one bank per value
        logic [OFFSET_WIDTH-1:0]        offset;
    } fsmc_addr_fld_t;

    typedef union packed {
        logic [ADDR_WIDTH_DEF-1:0] raw;
        fsmc_addr_fld_t            fld;
    } fsmc_addr_u;

    // strobes out of the synchronizer, all single-cycle except noe_low
    typedef struct packed {
        logic nadv_rise;
        logic nwe_rise;
        logic noe_rise;
        logic noe_low;   // level, not a pulse
    } fsmc_strobe_t;

    // one host access handed to the wishbone side
    typedef struct packed {
        logic                      valid;  // one-cycle pulse
        logic                      we;
        logic [CS_WIDTH_DEF-1:0]   region;
        logic [OFFSET_WIDTH-1:0]   offset;
        logic [DATA_WIDTH_DEF-1:0] wdata;
    } fsmc_req_t;

    // ==================================================================
    // wishbone classic, cyc is per region and kept outside
    // ==================================================================
    typedef struct packed {
        logic                      stb;
        logic                      we;
        logic [OFFSET_WIDTH-1:0]   adr;
        logic [DATA_WIDTH_DEF-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic                      ack;
        logic [DATA_WIDTH_DEF-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire
